// ==== trigger_cfg.svh ====
`ifndef TRIGGER_CFG_SVH
`define TRIGGER_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Frame geometry
//////////////////////////////////////////////////////////////////////

// Bins per FFT frame
`define TRIG_DEPTH 64

// Bin address width, log2 of the depth
`define TRIG_ADDR_W 6

//////////////////////////////////////////////////////////////////////
// Trigger evaluation
//////////////////////////////////////////////////////////////////////

// Fixed bin base added to the requested frequency
`define TRIG_BIN_BASE 9

// Threshold input is scaled by this before the compare
`define TRIG_THRESH_SCALE 11000

`endif

// ==== trigger_pkg.sv ====
`include "trigger_cfg.svh"

package trigger_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bin word views
    //////////////////////////////////////////////////////////////////////

    // One FFT bin, real part in the upper half
    typedef struct packed {
        logic signed [15:0] re;
        logic signed [15:0] im;
    } cplxBin_t;

    // Same 32 bits, seen raw by storage and as a complex pair by the evaluator
    typedef union packed {
        logic [31:0] raw;
        cplxBin_t    cplx;
    } binWord_u;

    //////////////////////////////////////////////////////////////////////
    // Memory write request
    //////////////////////////////////////////////////////////////////////

    // Capture stage to bin memory, 39 bits
    typedef struct packed {
        logic                    en;
        logic [`TRIG_ADDR_W-1:0] addr;
        binWord_u                data;
    } binWrite_t;

endpackage

// ==== binCapture.sv ====
`timescale 1ns/1ns

`include "trigger_cfg.svh"

module binCapture
    import trigger_pkg::*;
(
    input  logic      clk,
    input  logic      rstN,

    // Sample stream from the FFT core
    input  binWord_u  tData,
    input  logic      tValid,
    output logic      tReady,

    // Towards the bin memory
    output binWrite_t wrReq,

    // One pulse per accepted sample
    output logic      accept
);

    localparam int unsigned AddrW = `TRIG_ADDR_W;

    logic             readyReg;
    logic [AddrW-1:0] wrPtr;

    //////////////////////////////////////////////////////////////////////
    // Stream side
    //////////////////////////////////////////////////////////////////////

    // No back-pressure, ready rises once after reset and stays up
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readyReg <= 1'b0;
        end else begin
            readyReg <= 1'b1;
        end
    end

    assign tReady = readyReg;
    assign accept = tValid & readyReg;

    //////////////////////////////////////////////////////////////////////
    // Write pointer
    //////////////////////////////////////////////////////////////////////

    // Arrival order, wraps from the last bin back to 0
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
        end else if (accept) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write request packing
    //////////////////////////////////////////////////////////////////////

    // Word lands in memory on the accepting edge
    always_comb begin
        wrReq.en       = accept;
        wrReq.addr     = wrPtr;
        wrReq.data.raw = tData.raw;
    end

endmodule

// ==== binRam.sv ====
`timescale 1ns/1ns

`include "trigger_cfg.svh"

module binRam
    import trigger_pkg::*;
(
    input  logic                    clk,

    // Write port, driven by the capture stage
    input  binWrite_t               wrReq,

    // Read port, one cycle latency
    input  logic [`TRIG_ADDR_W-1:0] rdAddr,
    output binWord_u                rdData
);

    localparam int unsigned Depth = `TRIG_DEPTH;

    // Raw storage, one word per bin
    logic [31:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (wrReq.en) begin
            mem[wrReq.addr] <= wrReq.data.raw;
        end
    end

    // Read before write on a same-cycle collision
    always_ff @(posedge clk) begin
        rdData.raw <= mem[rdAddr];
    end

endmodule

// ==== frameCounter.sv ====
`timescale 1ns/1ns

`include "trigger_cfg.svh"

module frameCounter (
    input  logic clk,
    input  logic rstN,

    // Accepted sample strobe
    input  logic accept,

    // Single-cycle pulse after the last bin of a frame
    output logic frameReady
);

    localparam int unsigned AddrW = `TRIG_ADDR_W;
    localparam logic [AddrW-1:0] LastBin = AddrW'(`TRIG_DEPTH - 1);

    logic [AddrW-1:0] count;
    logic             lastAccept;

    assign lastAccept = accept && (count == LastBin);

    //////////////////////////////////////////////////////////////////////
    // Sample count within the frame
    //////////////////////////////////////////////////////////////////////

    // Natural wrap of the counter closes the frame
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count      <= '0;
            frameReady <= 1'b0;
        end else begin
            if (accept) begin
                count <= count + 1'b1;
            end
            // Idle gaps leave the count alone and drop the strobe
            frameReady <= lastAccept;
        end
    end

endmodule

// ==== binEnergy.sv ====
`timescale 1ns/1ns

`include "trigger_cfg.svh"

module binEnergy
    import trigger_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,

    // Bin selection and level
    input  logic [`TRIG_ADDR_W-1:0] frequency,
    input  logic [1:0]              offset,
    input  logic [15:0]             threshold,

    // Memory read port
    output logic [`TRIG_ADDR_W-1:0] rdAddr,
    input  binWord_u                rdData,

    output logic                    trigger
);

    localparam int unsigned AddrW = `TRIG_ADDR_W;
    localparam logic [AddrW-1:0] BinBase = AddrW'(`TRIG_BIN_BASE);
    localparam logic [32:0] ThreshScale = 33'(`TRIG_THRESH_SCALE);

    logic [AddrW-1:0] selAddr;
    logic [31:0]      reSq;
    logic [31:0]      imSq;
    logic [32:0]      energy;
    logic [32:0]      limit;

    //////////////////////////////////////////////////////////////////////
    // Read address
    //////////////////////////////////////////////////////////////////////

    // Natural bin index, modulo the frame size
    assign selAddr = frequency + BinBase + AddrW'(offset);

    // FFT core writes bins bit-reversed
    always_comb begin
        for (int i = 0; i < AddrW; i++) begin
            rdAddr[i] = selAddr[AddrW-1-i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Energy and compare
    //////////////////////////////////////////////////////////////////////

    // Squares are never negative, so the unsigned views are exact
    assign reSq   = rdData.cplx.re * rdData.cplx.re;
    assign imSq   = rdData.cplx.im * rdData.cplx.im;
    assign energy = {1'b0, reSq} + {1'b0, imSq};

    assign limit = {17'b0, threshold} * ThreshScale;

    // Strictly above the scaled threshold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            trigger <= 1'b0;
        end else begin
            trigger <= (energy > limit);
        end
    end

endmodule

// ==== triggerDetect.sv ====
`timescale 1ns/1ns

`include "trigger_cfg.svh"

module triggerDetect
    import trigger_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,

    // FFT bin stream
    input  binWord_u                tData,
    input  logic                    tValid,
    output logic                    tReady,

    // Trigger controls
    input  logic [15:0]             threshold,
    input  logic [`TRIG_ADDR_W-1:0] frequency,
    input  logic [1:0]              offset,

    output logic                    trigger,
    output logic                    frameReady
);

    binWrite_t               wrReq;
    logic                    accept;
    logic [`TRIG_ADDR_W-1:0] rdAddr;
    binWord_u                rdData;

    //////////////////////////////////////////////////////////////////////
    // Capture and storage
    //////////////////////////////////////////////////////////////////////

    binCapture binCapture_inst (
        .clk    (clk),
        .rstN   (rstN),
        .tData  (tData),
        .tValid (tValid),
        .tReady (tReady),
        .wrReq  (wrReq),
        .accept (accept)
    );

    binRam binRam_inst (
        .clk    (clk),
        .wrReq  (wrReq),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    // Frame boundary strobe
    frameCounter frameCounter_inst (
        .clk        (clk),
        .rstN       (rstN),
        .accept     (accept),
        .frameReady (frameReady)
    );

    //////////////////////////////////////////////////////////////////////
    // Evaluation
    //////////////////////////////////////////////////////////////////////

    binEnergy binEnergy_inst (
        .clk       (clk),
        .rstN      (rstN),
        .frequency (frequency),
        .offset    (offset),
        .threshold (threshold),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .trigger   (trigger)
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int Period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, 50 percent duty
    always begin
        #(Period / 2) clk = ~clk;
    end

endmodule

// ==== triggerDetect_assertions.sv ====
`timescale 1ns/1ns

module triggerDetect_assertions (
    input logic clk,
    input logic rstN,
    input logic tReady,
    input logic trigger,
    input logic frameReady
);

    // Failed assertions, read by the testbench at the end of the run
    int failCount = 0;

    // Frame strobe is a single-cycle pulse
    property frameReadySingle;
        @(posedge clk) disable iff (!rstN)
            frameReady |=> !frameReady;
    endproperty

    // Ready is up once reset has been released for a cycle
    property readyAfterReset;
        @(posedge clk) disable iff (!rstN)
            $past(rstN) |-> tReady;
    endproperty

    property triggerKnown;
        @(posedge clk) disable iff (!rstN)
            !$isunknown(trigger);
    endproperty

    assert property (frameReadySingle)
        else begin
            $error("frameReady high in two consecutive cycles");
            failCount++;
        end

    assert property (readyAfterReset)
        else begin
            $error("tReady low after reset release");
            failCount++;
        end

    assert property (triggerKnown)
        else begin
            $error("trigger is unknown after reset");
            failCount++;
        end

endmodule

bind triggerDetect triggerDetect_assertions triggerDetect_assertions_inst (
    .clk        (clk),
    .rstN       (rstN),
    .tReady     (tReady),
    .trigger    (trigger),
    .frameReady (frameReady)
);

// ==== triggerDetect_tb.sv ====
`timescale 1ns/1ns

`include "trigger_cfg.svh"

module triggerDetect_tb
    import trigger_pkg::*;
;

    localparam int NumTests    = 11;
    localparam int ClockPeriod = 40;

    // Bin values used by the table
    localparam logic [31:0] Loud    = {16'sd20000, 16'sd0};
    localparam logic [31:0] NegLoud = {-16'sd20000, 16'sd0};
    localparam logic [31:0] Quiet   = {16'sd10, 16'sd10};
    localparam logic [31:0] MaxNeg  = 32'h8000_8000;

    typedef struct packed {
        logic        sendFrame;
        logic [5:0]  frequency;
        logic [1:0]  offset;
        logic [15:0] threshold;
        logic [31:0] injectVal;
        logic        otherEn;
        logic [5:0]  otherBin;
        logic [31:0] otherVal;
        logic [3:0]  gap;
        logic        expTrigger;
    } stim_t;

    logic        clk;
    logic        rstN;
    binWord_u    tData;
    logic        tValid;
    logic        tReady;
    logic [15:0] threshold;
    logic [5:0]  frequency;
    logic [1:0]  offset;
    logic        trigger;
    logic        frameReady;

    string       testName [NumTests];
    stim_t       stimTab [NumTests];
    logic [31:0] modelMem [`TRIG_DEPTH];
    logic [31:0] lcgState = 32'd85434;
    logic        tableReady = 1'b0;
    logic        monitorOn = 1'b0;
    logic        frameDue = 1'b0;
    int          acceptCount = 0;
    int          framesSeen = 0;
    int          errorCount = 0;
    int          checkCount = 0;

    tbClock #(.Period(ClockPeriod)) tbClock_inst (.clk(clk));

    triggerDetect triggerDetect_inst (
        .clk        (clk),
        .rstN       (rstN),
        .tData      (tData),
        .tValid     (tValid),
        .tReady     (tReady),
        .threshold  (threshold),
        .frequency  (frequency),
        .offset     (offset),
        .trigger    (trigger),
        .frameReady (frameReady)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [5:0] bitReverse(input logic [5:0] a);
        logic [5:0] r;
        for (int b = 0; b < 6; b++) begin
            r[b] = a[5-b];
        end
        return r;
    endfunction

    // Arrival position of a natural bin index
    function automatic logic [5:0] storedPos(input int bin);
        return bitReverse(6'(bin % `TRIG_DEPTH));
    endfunction

    function automatic logic predictTrigger(input int freq, input int off, input int thr);
        logic [31:0]        word;
        logic signed [15:0] re;
        logic signed [15:0] im;
        longint             energy;
        longint             limit;
        word = modelMem[storedPos(freq + `TRIG_BIN_BASE + off)];
        re = word[31:16];
        im = word[15:0];
        energy = longint'(re) * longint'(re) + longint'(im) * longint'(im);
        limit = longint'(thr) * `TRIG_THRESH_SCALE;
        return energy > limit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    task automatic setEntry(input int idx, input string name, input bit send,
                            input int freq, input int off, input int thr,
                            input logic [31:0] inj, input bit otherEn, input int otherBin,
                            input logic [31:0] otherVal, input int gap, input bit expTrig);
        testName[idx]           = name;
        stimTab[idx].sendFrame  = send;
        stimTab[idx].frequency  = 6'(freq);
        stimTab[idx].offset     = 2'(off);
        stimTab[idx].threshold  = 16'(thr);
        stimTab[idx].injectVal  = inj;
        stimTab[idx].otherEn    = otherEn;
        stimTab[idx].otherBin   = 6'(otherBin);
        stimTab[idx].otherVal   = otherVal;
        stimTab[idx].gap        = 4'(gap);
        stimTab[idx].expTrigger = expTrig;
    endtask

    // Loud energy is 400000000 and the limit crosses it between 36363 and 36364
    task automatic loadTable();
        setEntry(0, "loud_bin", 1, 5, 0, 1000, Loud, 0, 0, 0, 0, 1);
        setEntry(1, "thresh_above", 1, 5, 0, 36364, Loud, 0, 0, 0, 0, 0);
        setEntry(2, "thresh_below", 1, 5, 0, 36363, Loud, 0, 0, 0, 0, 1);
        // 60 + 9 + 3 wraps to bin 8 with a decoy where a saturating sum would land
        setEntry(3, "wrap_quiet", 1, 60, 3, 1, Quiet, 1, 63, Loud, 0, 0);
        setEntry(4, "wrap_loud", 1, 60, 3, 1000, Loud, 1, 63, Quiet, 1, 1);
        // Signed real part squares to the same energy as Loud
        setEntry(5, "gap_negative", 1, 5, 0, 36364, NegLoud, 0, 0, 0, 3, 0);
        setEntry(6, "offset_a", 1, 20, 1, 1000, Loud, 1, 31, Quiet, 0, 1);
        setEntry(7, "offset_b", 0, 20, 2, 1000, 0, 0, 0, 0, 0, 0);
        setEntry(8, "offset_back", 0, 20, 1, 1000, 0, 0, 0, 0, 0, 1);
        setEntry(9, "zero_energy", 1, 0, 0, 0, 32'h0, 0, 0, 0, 2, 0);
        setEntry(10, "max_negative", 1, 50, 2, 65535, MaxNeg, 0, 0, 0, 1, 1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        errorCount++;
        $display("ERR %s expected %0d actual %0d", name, exp, act);
    endtask

    // Full frame in arrival order that returns 2 ns after an edge
    task automatic sendFrame(input int idx);
        logic [31:0] value;
        logic [5:0]  target;
        target = storedPos(stimTab[idx].frequency + `TRIG_BIN_BASE + stimTab[idx].offset);
        for (int pos = 0; pos < `TRIG_DEPTH; pos++) begin
            value = lcgNext();
            if (pos == target) begin
                value = stimTab[idx].injectVal;
            end else if (stimTab[idx].otherEn && pos == storedPos(stimTab[idx].otherBin)) begin
                value = stimTab[idx].otherVal;
            end
            modelMem[pos] = value;
            tValid = 1'b1;
            tData.raw = value;
            @(posedge clk);
            #2;
            tValid = 1'b0;
            for (int g = 0; g < stimTab[idx].gap; g++) begin
                // Junk on the bus while idle
                tData.raw = lcgNext();
                @(posedge clk);
                #2;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Frame strobe monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rstN && tValid) begin
            acceptCount = acceptCount + 1;
            frameDue = (acceptCount % `TRIG_DEPTH) == 0;
        end else begin
            frameDue = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (monitorOn) begin
            checkCount++;
            if (frameReady !== frameDue) begin
                reportMismatch("frame_ready", frameDue, frameReady);
            end
            if (tReady !== 1'b1) begin
                reportMismatch("tready_level", 1, tReady);
            end
            if (frameReady === 1'b1) begin
                framesSeen++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        int     maxGap;
        longint limitNs;
        wait (tableReady);
        maxGap = 0;
        for (int k = 0; k < NumTests; k++) begin
            if (stimTab[k].gap > maxGap) begin
                maxGap = stimTab[k].gap;
            end
        end
        limitNs = longint'(NumTests) * `TRIG_DEPTH * (maxGap + 1) * ClockPeriod
                  + NumTests * 10 * ClockPeriod + 2000;
        #(limitNs);
        $display("Watchdog expired, run did not finish within %0d ns", limitNs);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic modelTrig;
        int   assertFails;
        rstN      = 1'b0;
        tValid    = 1'b0;
        tData.raw = '0;
        threshold = '0;
        frequency = '0;
        offset    = '0;
        loadTable();
        tableReady = 1'b1;

        repeat (3) @(posedge clk);
        #2;
        checkCount++;
        if (trigger !== 1'b0 || frameReady !== 1'b0) begin
            reportMismatch("reset_outputs", 0, {trigger, frameReady});
        end
        rstN = 1'b1;

        // Ready rises on the first edge after release
        @(posedge clk);
        #2;
        checkCount++;
        if (tReady !== 1'b1 || trigger !== 1'b0 || frameReady !== 1'b0) begin
            reportMismatch("after_release", 3'b100, {tReady, trigger, frameReady});
        end
        monitorOn = 1'b1;

        for (int i = 0; i < NumTests; i++) begin
            if (stimTab[i].sendFrame) begin
                sendFrame(i);
            end
            frequency = stimTab[i].frequency;
            offset    = stimTab[i].offset;
            threshold = stimTab[i].threshold;
            // Two cycles of latency plus one spare
            repeat (3) @(posedge clk);
            #2;
            modelTrig = predictTrigger(frequency, offset, threshold);
            checkCount++;
            if (modelTrig !== stimTab[i].expTrigger) begin
                errorCount++;
                $display("Table entry %s disagrees with the model prediction", testName[i]);
            end
            checkCount++;
            if (trigger !== modelTrig) begin
                reportMismatch(testName[i], modelTrig, trigger);
            end
        end

        repeat (2) @(posedge clk);
        #2;
        monitorOn = 1'b0;
        checkCount++;
        if (framesSeen != acceptCount / `TRIG_DEPTH) begin
            reportMismatch("frame_count", acceptCount / `TRIG_DEPTH, framesSeen);
        end

        assertFails = triggerDetect_inst.triggerDetect_assertions_inst.failCount;
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
trigger_pkg.sv
binCapture.sv
binRam.sv
frameCounter.sv
binEnergy.sv
triggerDetect.sv
tbClock.sv
triggerDetect_assertions.sv
triggerDetect_tb.sv
